// ==== Makefile ====
TOP        ?= mmu_tb
RTL_TOP    ?= mmu_top
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_ARGS   ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== addr_translate.sv ====
`timescale 1ns/1ps

module addr_translate import mmu_pkg::*; (
    input  logic               clk,
    input  logic               resetn,
    input  logic               i_req,
    input  logic [31:0]        i_vaddr,
    input  logic               i_store,
    input  logic [7:0]         i_asid,
    tlb_search_if.requester    search,
    output logic               o_valid,
    output logic [31:0]        o_paddr,
    output logic               o_cached,
    output tlb_exc_e           o_exc
);

    logic [2:0]  seg;
    logic        unmapped;
    logic [31:0] paddr_d;
    logic        cached_d;
    tlb_exc_e    exc_d;

    assign seg      = i_vaddr[31:29];
    assign unmapped = (seg == SEG_KSEG0) || (seg == SEG_KSEG1);

    assign search.vpn2     = i_vaddr[31:13];
    assign search.odd_page = i_vaddr[12];
    assign search.asid     = i_asid;

    always_comb begin
        paddr_d  = '0;
        cached_d = 1'b0;
        exc_d    = EXC_NONE;
        if (unmapped) begin
            paddr_d  = {3'b000, i_vaddr[28:0]};
            cached_d = (seg == SEG_KSEG0); // kseg1 bypasses the cache
        end else if (!search.found) begin
            exc_d = EXC_REFILL;
        end else if (!search.v) begin
            exc_d = EXC_INVALID;
        end else if (i_store && !search.d) begin
            exc_d = EXC_MODIFIED; // Store to a clean page
        end else begin
            paddr_d  = {search.pfn, i_vaddr[11:0]};
            cached_d = (search.c == C_CACHEABLE);
        end
    end

    always_ff @(posedge clk) begin
        if (resetn) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_req;
        end
    end

    always_ff @(posedge clk) begin
        if (i_req) begin
            o_paddr  <= paddr_d;
            o_cached <= cached_d;
            o_exc    <= exc_d;
        end
    end

endmodule

// ==== mmu_assert.sv ====
`timescale 1ns/1ps

module mmu_assert import mmu_pkg::*; (
    input logic        clk,
    input logic        resetn,
    input logic        i_inst_req,
    input logic        o_inst_valid,
    input logic [31:0] o_inst_paddr,
    input tlb_exc_e    o_inst_exc,
    input logic        i_data_req,
    input logic        o_data_valid,
    input logic [31:0] o_data_paddr,
    input tlb_exc_e    o_data_exc,
    input logic        i_op_valid,
    input logic        o_op_done
);

    int fails = 0;

    reset_clears_pulses: assert property (
        @(posedge clk) resetn |=> (!o_inst_valid && !o_data_valid && !o_op_done)
    ) else begin
        fails++;
        $error("valid or done output is high in the cycle after reset");
    end

    inst_valid_follows_req: assert property (
        @(posedge clk) disable iff (resetn)
            !$past(resetn) |-> o_inst_valid == $past(i_inst_req)
    ) else begin
        fails++;
        $error("inst valid does not follow the request by one cycle");
    end

    data_valid_follows_req: assert property (
        @(posedge clk) disable iff (resetn)
            !$past(resetn) |-> o_data_valid == $past(i_data_req)
    ) else begin
        fails++;
        $error("data valid does not follow the request by one cycle");
    end

    op_done_follows_valid: assert property (
        @(posedge clk) disable iff (resetn)
            !$past(resetn) |-> o_op_done == $past(i_op_valid)
    ) else begin
        fails++;
        $error("op done does not follow the operation by one cycle");
    end

    // A faulting translation must not leak a physical address
    inst_exc_zero_paddr: assert property (
        @(posedge clk) (o_inst_valid && o_inst_exc != EXC_NONE) |-> o_inst_paddr == 32'd0
    ) else begin
        fails++;
        $error("inst paddr is not zero on an exception");
    end

    data_exc_zero_paddr: assert property (
        @(posedge clk) (o_data_valid && o_data_exc != EXC_NONE) |-> o_data_paddr == 32'd0
    ) else begin
        fails++;
        $error("data paddr is not zero on an exception");
    end

endmodule

bind mmu_top mmu_assert u_assert (.*);

// ==== mmu_checker.sv ====
`timescale 1ns/1ps

module mmu_checker import mmu_pkg::*; #(
    parameter int TLB_NUM = 16
) (
    input logic        clk,
    input logic        resetn,
    input logic        i_inst_req,
    input logic [31:0] i_inst_vaddr,
    input logic        o_inst_valid,
    input logic [31:0] o_inst_paddr,
    input logic        o_inst_cached,
    input tlb_exc_e    o_inst_exc,
    input logic        i_data_req,
    input logic [31:0] i_data_vaddr,
    input logic        i_data_store,
    input logic        o_data_valid,
    input logic [31:0] o_data_paddr,
    input logic        o_data_cached,
    input tlb_exc_e    o_data_exc,
    input logic        i_op_valid,
    input tlb_op_e     i_op,
    input logic [31:0] i_op_data,
    input logic        o_op_done,
    input logic [31:0] o_index,
    input logic [31:0] o_entryhi,
    input logic [31:0] o_entrylo0,
    input logic [31:0] o_entrylo1
);

    localparam int IDX_W = $clog2(TLB_NUM);

    tlb_entry_t       model_tlb [TLB_NUM];
    logic [31:0]      m_index;
    logic [31:0]      m_entryhi;
    logic [31:0]      m_entrylo0;
    logic [31:0]      m_entrylo1;
    logic [IDX_W-1:0] m_random;
    logic             pend_inst = 1'b0;
    logic             pend_data = 1'b0;
    logic             pend_op = 1'b0;
    logic [34:0]      exp_inst; // {exc, cached, paddr}
    logic [34:0]      exp_data;
    string            test_name = "none";
    int               test_checks = 0;
    int               test_errors = 0;
    int               total_checks = 0;
    int               total_errors = 0;
    int               tests_run = 0;

    ////////////////////////////////////////////////////////////////////
    // Reference model

    // Returns {found, index}; with duplicates the last match wins
    function automatic logic [IDX_W:0] model_search(input logic [18:0] vpn2,
                                                    input logic [7:0] asid);
        logic [IDX_W:0] res;
        res = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            if (model_tlb[i].vpn2 == vpn2 && (model_tlb[i].asid == asid || model_tlb[i].g)) begin
                res = {1'b1, IDX_W'(i)};
            end
        end
        return res;
    endfunction

    function automatic logic [34:0] ref_translate(input logic [31:0] va, input logic store);
        logic [IDX_W:0] hit;
        tlb_entry_t     e;
        logic [19:0]    pfn;
        logic [2:0]     c;
        logic           d;
        logic           v;
        if (va[31:29] == 3'b100 || va[31:29] == 3'b101) begin
            return {EXC_NONE, va[31:29] == 3'b100, 3'b000, va[28:0]};
        end
        hit = model_search(va[31:13], m_entryhi[7:0]);
        e   = model_tlb[hit[IDX_W-1:0]];
        pfn = va[12] ? e.pfn1 : e.pfn0; // Bit 12 picks the odd page
        c   = va[12] ? e.c1 : e.c0;
        d   = va[12] ? e.d1 : e.d0;
        v   = va[12] ? e.v1 : e.v0;
        if (!hit[IDX_W]) return {EXC_REFILL, 33'd0};
        if (!v) return {EXC_INVALID, 33'd0};
        if (store && !d) return {EXC_MODIFIED, 33'd0};
        return {EXC_NONE, c == 3'd3, pfn, va[11:0]};
    endfunction

    task automatic apply_op(input tlb_op_e op, input logic [31:0] data);
        logic [IDX_W:0] hit;
        tlb_entry_t     e;
        case (op)
            OP_MTC0_INDEX:    m_index    = {data[31], 31'(data[IDX_W-1:0])};
            OP_MTC0_ENTRYHI:  m_entryhi  = {data[31:13], 5'd0, data[7:0]};
            OP_MTC0_ENTRYLO0: m_entrylo0 = {6'd0, data[25:0]};
            OP_MTC0_ENTRYLO1: m_entrylo1 = {6'd0, data[25:0]};
            OP_TLBP: begin
                hit = model_search(m_entryhi[31:13], m_entryhi[7:0]);
                if (hit[IDX_W]) begin
                    m_index = 32'(hit[IDX_W-1:0]);
                end else begin
                    m_index[31] = 1'b1;
                end
            end
            OP_TLBR: begin
                e          = model_tlb[m_index[IDX_W-1:0]];
                m_entryhi  = {e.vpn2, 5'd0, e.asid};
                m_entrylo0 = {6'd0, e.pfn0, e.c0, e.d0, e.v0, e.g};
                m_entrylo1 = {6'd0, e.pfn1, e.c1, e.d1, e.v1, e.g};
            end
            default: begin
                // EntryLo bits 25:1 hold {pfn, c, d, v} in entry order
                e = {m_entryhi[31:13], m_entryhi[7:0], m_entrylo0[0] & m_entrylo1[0],
                     m_entrylo0[25:1], m_entrylo1[25:1]};
                model_tlb[(op == OP_TLBWR) ? m_random : m_index[IDX_W-1:0]] = e;
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////
    // Comparison and reporting

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        test_checks++;
        total_checks++;
        if (exp !== act) begin
            test_errors++;
            total_errors++;
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic report_fault(input string msg);
        test_errors++;
        total_errors++;
        $display("ERROR %s: %s", test_name, msg);
    endtask

    task automatic check_xlat(input string path, input logic pend, input logic [34:0] exp,
                              input logic valid, input logic [31:0] paddr,
                              input logic cached, input logic [1:0] exc);
        if (pend && !valid) begin
            report_fault({path, " result did not arrive one cycle after its request"});
        end else if (!pend && valid) begin
            report_fault({path, " result arrived without a request"});
        end else if (valid) begin
            compare({path, " exc"}, 32'(exp[34:33]), 32'(exc));
            compare({path, " cached"}, 32'(exp[32]), 32'(cached));
            compare({path, " paddr"}, exp[31:0], paddr);
        end
    endtask

    task automatic check_op();
        if (pend_op && !o_op_done) begin
            report_fault("CP0 operation did not signal done in the next cycle");
        end else if (!pend_op && o_op_done) begin
            report_fault("CP0 done pulse arrived without an operation");
        end else if (o_op_done) begin
            compare("index", m_index, o_index);
            compare("entryhi", m_entryhi, o_entryhi);
            compare("entrylo0", m_entrylo0, o_entrylo0);
            compare("entrylo1", m_entrylo1, o_entrylo1);
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
    endtask

    always @(posedge clk) begin
        if (resetn) begin
            model_tlb  = '{default: '0};
            m_index    = '0;
            m_entryhi  = '0;
            m_entrylo0 = '0;
            m_entrylo1 = '0;
            m_random   = IDX_W'(TLB_NUM - 1);
            pend_inst  = 1'b0;
            pend_data  = 1'b0;
            pend_op    = 1'b0;
        end else begin
            check_xlat("inst", pend_inst, exp_inst, o_inst_valid, o_inst_paddr,
                       o_inst_cached, o_inst_exc);
            check_xlat("data", pend_data, exp_data, o_data_valid, o_data_paddr,
                       o_data_cached, o_data_exc);
            check_op();
            pend_inst = i_inst_req;
            pend_data = i_data_req;
            pend_op   = i_op_valid;
            // Lookups see the TLB before a write landing at this edge
            if (i_inst_req) exp_inst = ref_translate(i_inst_vaddr, 1'b0);
            if (i_data_req) exp_data = ref_translate(i_data_vaddr, i_data_store);
            if (i_op_valid) apply_op(i_op, i_op_data);
            m_random = m_random - IDX_W'(1);
        end
    end

endmodule

// ==== mmu_pkg.sv ====
package mmu_pkg;

    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        g;
        logic [19:0] pfn0;
        logic [2:0]  c0;
        logic        d0;
        logic        v0;
        logic [19:0] pfn1;
        logic [2:0]  c1;
        logic        d1;
        logic        v1;
    } tlb_entry_t;

    typedef enum logic [2:0] {
        OP_MTC0_INDEX,
        OP_MTC0_ENTRYHI,
        OP_MTC0_ENTRYLO0,
        OP_MTC0_ENTRYLO1,
        OP_TLBP,
        OP_TLBR,
        OP_TLBWI,
        OP_TLBWR
    } tlb_op_e;

    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_REFILL,
        EXC_INVALID,
        EXC_MODIFIED
    } tlb_exc_e;

    //////////////////////////////////////////////////////////////////////
    // CP0 register fields

    localparam int ELO_PFN_HI  = 25;
    localparam int ELO_PFN_LO  = 6;
    localparam int ELO_C_HI    = 5;
    localparam int ELO_C_LO    = 3;
    localparam int ELO_D       = 2;
    localparam int ELO_V       = 1;
    localparam int ELO_G       = 0;
    localparam int EHI_VPN2_HI = 31;
    localparam int EHI_VPN2_LO = 13;
    localparam int EHI_ASID_HI = 7;
    localparam int EHI_ASID_LO = 0;
    localparam int INDEX_P     = 31;

    localparam logic [31:0] ENTRYLO_MASK = 32'h03ff_ffff;
    localparam logic [31:0] ENTRYHI_MASK = 32'hffff_e0ff;

    localparam logic [2:0] SEG_KSEG0   = 3'b100;
    localparam logic [2:0] SEG_KSEG1   = 3'b101;
    localparam logic [2:0] C_CACHEABLE = 3'd3;

endpackage

// ==== mmu_tb.sv ====
`timescale 1ns/1ps

module mmu_tb import mmu_pkg::*; ();

    localparam int TLB_NUM    = 16;
    localparam int IDX_W      = $clog2(TLB_NUM);
    localparam int REPS       = 8;
    localparam int OPS_TOTAL  = 6 * REPS + 9 * TLB_NUM + 12; // Request cycles plus CP0 ops
    localparam int MAX_CYCLES = 4 * OPS_TOTAL + 200;

    logic        clk;
    logic        resetn;
    logic        i_inst_req;
    logic [31:0] i_inst_vaddr;
    logic        o_inst_valid;
    logic [31:0] o_inst_paddr;
    logic        o_inst_cached;
    tlb_exc_e    o_inst_exc;
    logic        i_data_req;
    logic [31:0] i_data_vaddr;
    logic        i_data_store;
    logic        o_data_valid;
    logic [31:0] o_data_paddr;
    logic        o_data_cached;
    tlb_exc_e    o_data_exc;
    logic        i_op_valid;
    tlb_op_e     i_op;
    logic [31:0] i_op_data;
    logic        o_op_done;
    logic [31:0] o_index;
    logic [31:0] o_entryhi;
    logic [31:0] o_entrylo0;
    logic [31:0] o_entrylo1;

    logic [31:0] lfsr = 32'hc33a357e;
    logic [31:0] ent_hi [TLB_NUM]; // EntryHi value used for each written entry
    int          cycles = 0;

    tb_clock #(.RESET_CYCLES(8)) u_clock (.clk, .resetn);

    mmu_top #(.TLB_NUM(TLB_NUM)) dut (.*);

    mmu_checker #(.TLB_NUM(TLB_NUM)) u_chk (.*);

    ////////////////////////////////////////////////////////////////////
    // Random numbers

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Stimulus

    task automatic do_op(input tlb_op_e op, input logic [31:0] data);
        @(posedge clk);
        #1;
        i_op_valid = 1'b1;
        i_op       = op;
        i_op_data  = data;
        @(posedge clk);
        #1;
        i_op_valid = 1'b0;
        while (!o_op_done) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic send_xlat(input logic inst_req, input logic [31:0] inst_va,
                             input logic data_req, input logic [31:0] data_va,
                             input logic store);
        @(posedge clk);
        #1;
        i_inst_req   = inst_req;
        i_inst_vaddr = inst_va;
        i_data_req   = data_req;
        i_data_vaddr = data_va;
        i_data_store = store;
    endtask

    // Even and odd page of every entry on both paths, back to back
    task automatic sweep_entries();
        logic [31:0] va;
        for (int i = 0; i < TLB_NUM; i++) begin
            va = (ent_hi[i] & 32'hffff_e000) | rand_bits(13);
            send_xlat(1'b1, va, 1'b1, va ^ 32'h1000, rand_bits(1) != 32'd0);
            send_xlat(1'b1, va ^ 32'h1000, 1'b1, va, rand_bits(1) != 32'd0);
        end
    endtask

    task automatic close_test();
        send_xlat(1'b0, 32'd0, 1'b0, 32'd0, 1'b0);
        repeat (2) @(posedge clk);
        #1;
        u_chk.end_test();
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: the run went past %0d cycles", MAX_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    initial begin : test_sequence
        logic [31:0] hi;
        logic [7:0]  asid_a;
        int          k;
        i_inst_req   = 1'b1; // Requests stay high through reset so reset has to win
        i_inst_vaddr = '0;
        i_data_req   = 1'b1;
        i_data_vaddr = '0;
        i_data_store = 1'b0;
        i_op_valid   = 1'b1;
        i_op         = OP_MTC0_INDEX;
        i_op_data    = '0;
        wait (!resetn);
        i_inst_req   = 1'b0;
        i_data_req   = 1'b0;
        i_op_valid   = 1'b0;

        u_chk.begin_test("unmapped");
        for (int i = 0; i < REPS; i++) begin
            send_xlat(1'b1, 32'h8000_0000 | rand_bits(30), 1'b1,
                      32'h8000_0000 | rand_bits(30), rand_bits(1) != 32'd0);
        end
        close_test();

        u_chk.begin_test("refill");
        for (int i = 0; i < REPS; i++) begin
            send_xlat(1'b1, 32'hc000_0000 | rand_bits(30), 1'b1,
                      32'h4000_0000 | rand_bits(30), rand_bits(1) != 32'd0);
        end
        close_test();

        u_chk.begin_test("mapped");
        asid_a = 8'(rand_bits(8));
        for (int i = 0; i < TLB_NUM; i++) begin
            hi = rand_bits(31); // kuseg only, so kseg2 stays free for a fresh VPN2
            if (i % 2 == 0) hi[7:0] = asid_a;
            ent_hi[i] = hi;
            do_op(OP_MTC0_INDEX, 32'(i));
            do_op(OP_MTC0_ENTRYHI, hi);
            do_op(OP_MTC0_ENTRYLO0, rand_bits(32));
            do_op(OP_MTC0_ENTRYLO1, rand_bits(32));
            do_op(OP_TLBWI, 32'd0);
        end
        do_op(OP_MTC0_ENTRYHI, {24'd0, asid_a});
        sweep_entries();
        do_op(OP_MTC0_ENTRYHI, {24'd0, ~asid_a}); // Only global entries still hit
        sweep_entries();
        close_test();

        u_chk.begin_test("tlbr");
        for (int i = 0; i < REPS; i++) begin
            do_op(OP_MTC0_INDEX, rand_bits(IDX_W));
            do_op(OP_TLBR, 32'd0);
        end
        close_test();

        u_chk.begin_test("tlbp");
        for (int i = 0; i < REPS; i++) begin
            k = int'(rand_bits(IDX_W));
            do_op(OP_MTC0_ENTRYHI, ent_hi[k]);
            do_op(OP_TLBP, 32'd0);
        end
        do_op(OP_MTC0_ENTRYHI, 32'h8000_0000 | rand_bits(31));
        do_op(OP_TLBP, 32'd0);
        close_test();

        u_chk.begin_test("tlbwr");
        hi = 32'hc000_0000 | rand_bits(29);
        do_op(OP_MTC0_ENTRYHI, hi);
        do_op(OP_MTC0_ENTRYLO0, rand_bits(32) | 32'h6);
        do_op(OP_MTC0_ENTRYLO1, rand_bits(32) | 32'h6);
        do_op(OP_TLBWR, 32'd0);
        do_op(OP_TLBP, 32'd0);
        do_op(OP_TLBR, 32'd0);
        send_xlat(1'b1, (hi & 32'hffff_e000) | rand_bits(13), 1'b1,
                  (hi & 32'hffff_e000) | rand_bits(13), 1'b1);
        send_xlat(1'b1, (hi & 32'hffff_e000) | rand_bits(13), 1'b1,
                  (hi & 32'hffff_e000) | rand_bits(13), 1'b0);
        close_test();

        $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 u_chk.tests_run, u_chk.total_checks, u_chk.total_errors,
                 dut.u_assert.fails);
        if (u_chk.total_errors == 0 && dut.u_assert.fails == 0 && u_chk.total_checks > 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== mmu_top.sv ====
`timescale 1ns/1ps

module mmu_top import mmu_pkg::*; #(
    parameter int TLB_NUM = 16
) (
    input  logic        clk,
    input  logic        resetn,
    input  logic        i_inst_req,
    input  logic [31:0] i_inst_vaddr,
    output logic        o_inst_valid,
    output logic [31:0] o_inst_paddr,
    output logic        o_inst_cached,
    output tlb_exc_e    o_inst_exc,
    input  logic        i_data_req,
    input  logic [31:0] i_data_vaddr,
    input  logic        i_data_store,
    output logic        o_data_valid,
    output logic [31:0] o_data_paddr,
    output logic        o_data_cached,
    output tlb_exc_e    o_data_exc,
    input  logic        i_op_valid,
    input  tlb_op_e     i_op,
    input  logic [31:0] i_op_data,
    output logic        o_op_done,
    output logic [31:0] o_index,
    output logic [31:0] o_entryhi,
    output logic [31:0] o_entrylo0,
    output logic [31:0] o_entrylo1
);

    logic [7:0] asid;

    tlb_search_if #(.TLB_NUM(TLB_NUM)) inst_search ();
    tlb_search_if #(.TLB_NUM(TLB_NUM)) data_search ();
    tlb_search_if #(.TLB_NUM(TLB_NUM)) probe_search ();
    tlb_access_if #(.TLB_NUM(TLB_NUM)) tlb_access ();

    tlb #(.TLB_NUM(TLB_NUM)) u_tlb (
        .clk, .resetn,
        .search_inst(inst_search), .search_data(data_search),
        .search_probe(probe_search), .access(tlb_access)
    );

    addr_translate u_inst_xlat (
        .clk, .resetn, .i_req(i_inst_req), .i_vaddr(i_inst_vaddr),
        .i_store(1'b0), .i_asid(asid), .search(inst_search), // Fetches never store
        .o_valid(o_inst_valid), .o_paddr(o_inst_paddr),
        .o_cached(o_inst_cached), .o_exc(o_inst_exc)
    );

    addr_translate u_data_xlat (
        .clk, .resetn, .i_req(i_data_req), .i_vaddr(i_data_vaddr),
        .i_store(i_data_store), .i_asid(asid), .search(data_search),
        .o_valid(o_data_valid), .o_paddr(o_data_paddr),
        .o_cached(o_data_cached), .o_exc(o_data_exc)
    );

    tlb_ctrl #(.TLB_NUM(TLB_NUM)) u_tlb_ctrl (
        .clk, .resetn, .i_op_valid, .i_op, .i_op_data,
        .probe(probe_search), .access(tlb_access),
        .o_op_done, .o_index, .o_entryhi, .o_entrylo0, .o_entrylo1,
        .o_asid(asid)
    );

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    initial begin
        resetn = 1'b1; // Reset is active high
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        resetn = 1'b0;
    end

endmodule

// ==== tlb.sv ====
`timescale 1ns/1ps

module tlb import mmu_pkg::*; #(
    parameter int TLB_NUM = 16
) (
    input  logic      clk,
    input  logic      resetn,
    tlb_search_if.tlb search_inst,
    tlb_search_if.tlb search_data,
    tlb_search_if.tlb search_probe,
    tlb_access_if.tlb access
);

    localparam int IDX_W = $clog2(TLB_NUM);

    typedef struct packed {
        logic             found;
        logic [IDX_W-1:0] index;
        logic [19:0]      pfn;
        logic [2:0]       c;
        logic             d;
        logic             v;
    } tlb_search_t;

    tlb_entry_t tlb_ram [TLB_NUM];

    //////////////////////////////////////////////////////////////////////
    // Associative lookup shared by all three search ports

    function automatic tlb_search_t lookup(
        input logic [18:0] vpn2,
        input logic        odd_page,
        input logic [7:0]  asid
    );
        tlb_search_t        res;
        tlb_entry_t         hit;
        logic [TLB_NUM-1:0] match;
        res = '0;
        for (int i = 0; i < TLB_NUM; i++) begin
            match[i] = (tlb_ram[i].vpn2 == vpn2) && ((tlb_ram[i].asid == asid) || tlb_ram[i].g);
            if (match[i]) begin
                res.index = res.index | IDX_W'(i); // Entries are assumed unique
            end
        end
        res.found = |match;
        hit = tlb_ram[res.index];
        res.pfn = odd_page ? hit.pfn1 : hit.pfn0;
        res.c   = odd_page ? hit.c1   : hit.c0;
        res.d   = odd_page ? hit.d1   : hit.d0;
        res.v   = odd_page ? hit.v1   : hit.v0;
        return res;
    endfunction

    always_comb begin
        {search_inst.found, search_inst.index, search_inst.pfn,
         search_inst.c, search_inst.d, search_inst.v} =
            lookup(search_inst.vpn2, search_inst.odd_page, search_inst.asid);
    end

    always_comb begin
        {search_data.found, search_data.index, search_data.pfn,
         search_data.c, search_data.d, search_data.v} =
            lookup(search_data.vpn2, search_data.odd_page, search_data.asid);
    end

    always_comb begin
        {search_probe.found, search_probe.index, search_probe.pfn,
         search_probe.c, search_probe.d, search_probe.v} =
            lookup(search_probe.vpn2, search_probe.odd_page, search_probe.asid);
    end

    //////////////////////////////////////////////////////////////////////
    // Entry array

    always_ff @(posedge clk) begin
        if (resetn) begin
            tlb_ram <= '{default: '0}; // Every entry comes up invalid
        end else if (access.we) begin
            tlb_ram[access.w_index] <= access.w_entry;
        end
    end

    assign access.r_entry = tlb_ram[access.r_index];

endmodule

// ==== tlb_access_if.sv ====
`timescale 1ns/1ps

interface tlb_access_if import mmu_pkg::*; #(
    parameter int TLB_NUM = 16
);
    localparam int IDX_W = $clog2(TLB_NUM);

    logic [IDX_W-1:0] r_index;
    tlb_entry_t       r_entry;
    logic             we;
    logic [IDX_W-1:0] w_index;
    tlb_entry_t       w_entry;

    modport ctrl (output r_index, we, w_index, w_entry, input r_entry);
    modport tlb (input r_index, we, w_index, w_entry, output r_entry);
endinterface

// ==== tlb_ctrl.sv ====
`timescale 1ns/1ps

module tlb_ctrl import mmu_pkg::*; #(
    parameter int TLB_NUM = 16
) (
    input  logic            clk,
    input  logic            resetn,
    input  logic            i_op_valid,
    input  tlb_op_e         i_op,
    input  logic [31:0]     i_op_data,
    tlb_search_if.requester probe,
    tlb_access_if.ctrl      access,
    output logic            o_op_done,
    output logic [31:0]     o_index,
    output logic [31:0]     o_entryhi,
    output logic [31:0]     o_entrylo0,
    output logic [31:0]     o_entrylo1,
    output logic [7:0]      o_asid
);

    localparam int          IDX_W      = $clog2(TLB_NUM);
    localparam logic [31:0] INDEX_MASK = (32'd1 << INDEX_P) | ((32'd1 << IDX_W) - 32'd1);

    logic [IDX_W-1:0] random_q;
    tlb_entry_t       w_entry;

    function automatic logic [31:0] pack_lo(
        input logic [19:0] pfn,
        input logic [2:0]  c,
        input logic        d,
        input logic        v,
        input logic        g
    );
        logic [31:0] lo;
        lo = '0;
        lo[ELO_PFN_HI:ELO_PFN_LO] = pfn;
        lo[ELO_C_HI:ELO_C_LO]     = c;
        lo[ELO_D]                 = d;
        lo[ELO_V]                 = v;
        lo[ELO_G]                 = g;
        return lo;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Search, read and write ports

    assign probe.vpn2     = o_entryhi[EHI_VPN2_HI:EHI_VPN2_LO];
    assign probe.odd_page = 1'b0;
    assign probe.asid     = o_asid;
    assign o_asid         = o_entryhi[EHI_ASID_HI:EHI_ASID_LO];

    always_comb begin
        w_entry      = '0;
        w_entry.vpn2 = o_entryhi[EHI_VPN2_HI:EHI_VPN2_LO];
        w_entry.asid = o_asid;
        w_entry.g    = o_entrylo0[ELO_G] & o_entrylo1[ELO_G]; // Global only if both halves say so
        w_entry.pfn0 = o_entrylo0[ELO_PFN_HI:ELO_PFN_LO];
        w_entry.c0   = o_entrylo0[ELO_C_HI:ELO_C_LO];
        w_entry.d0   = o_entrylo0[ELO_D];
        w_entry.v0   = o_entrylo0[ELO_V];
        w_entry.pfn1 = o_entrylo1[ELO_PFN_HI:ELO_PFN_LO];
        w_entry.c1   = o_entrylo1[ELO_C_HI:ELO_C_LO];
        w_entry.d1   = o_entrylo1[ELO_D];
        w_entry.v1   = o_entrylo1[ELO_V];
    end

    assign access.r_index = o_index[IDX_W-1:0];
    assign access.we      = i_op_valid && (i_op == OP_TLBWI || i_op == OP_TLBWR);
    assign access.w_index = (i_op == OP_TLBWR) ? random_q : o_index[IDX_W-1:0];
    assign access.w_entry = w_entry;

    always_ff @(posedge clk) begin
        if (resetn) begin
            o_op_done  <= 1'b0;
            o_index    <= '0;
            o_entryhi  <= '0;
            o_entrylo0 <= '0;
            o_entrylo1 <= '0;
            random_q   <= IDX_W'(TLB_NUM - 1);
        end else begin
            o_op_done <= i_op_valid;
            random_q  <= random_q - 1'b1; // Wraps from 0 to TLB_NUM-1
            if (i_op_valid) begin
                case (i_op)
                    OP_MTC0_INDEX:    o_index    <= i_op_data & INDEX_MASK;
                    OP_MTC0_ENTRYHI:  o_entryhi  <= i_op_data & ENTRYHI_MASK;
                    OP_MTC0_ENTRYLO0: o_entrylo0 <= i_op_data & ENTRYLO_MASK;
                    OP_MTC0_ENTRYLO1: o_entrylo1 <= i_op_data & ENTRYLO_MASK;
                    OP_TLBP: begin
                        if (probe.found) begin
                            o_index <= 32'(probe.index);
                        end else begin
                            o_index[INDEX_P] <= 1'b1; // Index field stays as it was
                        end
                    end
                    OP_TLBR: begin
                        o_entryhi <= {access.r_entry.vpn2, 5'b0, access.r_entry.asid};
                        o_entrylo0 <= pack_lo(access.r_entry.pfn0, access.r_entry.c0,
                                              access.r_entry.d0, access.r_entry.v0,
                                              access.r_entry.g);
                        o_entrylo1 <= pack_lo(access.r_entry.pfn1, access.r_entry.c1,
                                              access.r_entry.d1, access.r_entry.v1,
                                              access.r_entry.g);
                    end
                    default: ; // TLBWI and TLBWR go out on the write port
                endcase
            end
        end
    end

endmodule

// ==== tlb_search_if.sv ====
`timescale 1ns/1ps

interface tlb_search_if #(
    parameter int TLB_NUM = 16
);
    localparam int IDX_W = $clog2(TLB_NUM);

    logic [18:0]      vpn2;
    logic             odd_page;
    logic [7:0]       asid;
    logic             found;
    logic [IDX_W-1:0] index;
    logic [19:0]      pfn;
    logic [2:0]       c;
    logic             d;
    logic             v;

    modport requester (output vpn2, odd_page, asid, input found, index, pfn, c, d, v);
    modport tlb (input vpn2, odd_page, asid, output found, index, pfn, c, d, v);
endinterface

// ==== vlog.f ====
mmu_pkg.sv
tlb_search_if.sv
tlb_access_if.sv
tlb.sv
addr_translate.sv
tlb_ctrl.sv
mmu_top.sv
tb_clock.sv
mmu_assert.sv
mmu_checker.sv
mmu_tb.sv
